// ==== hw/ts_remap_pkg.sv ====
package ts_remap_pkg;

    typedef logic [32:0] ts_word_t;    // [32] start flag, [31:0] data
    typedef logic [12:0] pid_t;
    typedef logic [15:0] pid_seq_t;
    typedef logic [7:0]  sfp_t;        // ingress port number
    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] udp_port_t;   // zero means do not forward
    typedef logic [5:0]  word_idx_t;   // position inside an output packet

    localparam int TS_WORDS  = 47;
    localparam int HDR_WORDS = 4;
    localparam int OUT_WORDS = HDR_WORDS + TS_WORDS;
    localparam int CFG_BYTES = 14;

    // one route entry, 99 bits
    typedef struct packed {
        logic      valid;
        pid_t      pid;        // match pid
        pid_seq_t  seq;
        sfp_t      sfp;
        ip_addr_t  ip;
        udp_port_t port;
        pid_t      new_pid;    // written into packet word 0
    } route_entry_t;

    typedef enum logic [2:0] {
        st_idle,
        st_search,
        st_wait_credit,
        st_send,
        st_discard
    } remap_state_t;

endpackage

// ==== hw/route_cfg_parser.sv ====
`timescale 1ns/1ps

module route_cfg_parser #(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic [7:0]                       cfg_din,
    input  logic                             cfg_din_en,
    output logic                             wr_en,
    output logic [$clog2(TABLE_DEPTH)-1:0]   wr_index,
    output ts_remap_pkg::route_entry_t       wr_entry
);

    localparam int         IDX_W     = $clog2(TABLE_DEPTH);
    localparam logic [3:0] LAST_BYTE = 4'(ts_remap_pkg::CFG_BYTES - 1);

    logic [3:0]   byte_cnt;
    logic [103:0] msg_q;       // first 13 bytes, oldest on top
    logic [111:0] msg_full;    // whole message once the last byte arrives
    logic         last_byte;

    assign msg_full  = {msg_q, cfg_din};
    assign last_byte = cfg_din_en && (byte_cnt == LAST_BYTE);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            byte_cnt <= '0;
            wr_en    <= 1'b0;
        end
        else
        begin
            wr_en <= last_byte;
            if (!cfg_din_en || last_byte)
                byte_cnt <= '0;    // gap drops a partial message
            else
                byte_cnt <= byte_cnt + 4'd1;
        end
    end

    always_ff @(posedge clk)
    begin
        if (cfg_din_en)
            msg_q <= {msg_q[95:0], cfg_din};
        if (last_byte)
        begin
            wr_index         <= msg_full[104 +: IDX_W];    // low bits of byte 0
            wr_entry.valid   <= 1'b1;
            wr_entry.pid     <= msg_full[100:88];
            wr_entry.seq     <= msg_full[87:72];
            wr_entry.sfp     <= msg_full[71:64];
            wr_entry.ip      <= msg_full[63:32];
            wr_entry.port    <= msg_full[31:16];
            wr_entry.new_pid <= msg_full[12:0];
        end
    end

endmodule

// ==== hw/pid_route_table.sv ====
`timescale 1ns/1ps

module pid_route_table #(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wr_en,
    input  logic [$clog2(TABLE_DEPTH)-1:0]   wr_index,
    input  ts_remap_pkg::route_entry_t       wr_entry,
    input  logic [$clog2(TABLE_DEPTH)-1:0]   rd_index,
    output ts_remap_pkg::route_entry_t       rd_entry
);

    ts_remap_pkg::route_entry_t entries [TABLE_DEPTH];

    //////////////////////////////////////////////////
    // write port

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < TABLE_DEPTH; i++)
                entries[i].valid <= 1'b0;    // only the valid bits clear
        end
        else if (wr_en)
        begin
            entries[wr_index] <= wr_entry;   // whole entry replaced
        end
    end

    //////////////////////////////////////////////////
    // read port

    assign rd_entry = entries[rd_index];     // combinational lookup

endmodule

// ==== hw/ts_packet_buffer.sv ====
`timescale 1ns/1ps

module ts_packet_buffer #(
    parameter int BUF_DEPTH = 128
) (
    input  logic                    clk,
    input  logic                    rst,
    input  ts_remap_pkg::ts_word_t  ts_din,
    input  logic                    ts_din_en,
    input  logic                    pop,
    output ts_remap_pkg::ts_word_t  head_word,
    output logic                    pkt_ready
);

    localparam int AW = $clog2(BUF_DEPTH);

    ts_remap_pkg::ts_word_t mem [BUF_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   fill;
    logic          push_ok;
    logic          pop_ok;

    assign push_ok = ts_din_en && (fill != (AW + 1)'(BUF_DEPTH));  // full drops the word
    assign pop_ok  = pop && (fill != '0);

    always_ff @(posedge clk)
    begin
        if (push_ok)
            mem[wr_ptr] <= ts_din;
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end
        else
        begin
            if (push_ok)
                wr_ptr <= (wr_ptr == AW'(BUF_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop_ok)
                rd_ptr <= (rd_ptr == AW'(BUF_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            fill <= fill + (AW + 1)'(push_ok) - (AW + 1)'(pop_ok);
        end
    end

    assign head_word = mem[rd_ptr];    // show-ahead
    assign pkt_ready = (fill >= (AW + 1)'(ts_remap_pkg::TS_WORDS));

endmodule

// ==== hw/egress_credit_counter.sv ====
`timescale 1ns/1ps

module egress_credit_counter #(
    parameter int CREDIT_MAX = 64
) (
    input  logic clk,
    input  logic rst,
    input  logic credit_return,
    input  logic spend,
    output logic credit_ok
);

    localparam int CW = $clog2(CREDIT_MAX + 1);

    logic [CW-1:0] count;
    logic [CW-1:0] count_nxt;
    logic          inc;
    logic          dec;

    assign dec       = spend && (count != '0);
    assign inc       = credit_return && ((count != CW'(CREDIT_MAX)) || dec);  // saturate
    assign count_nxt = count + CW'(inc) - CW'(dec);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count     <= '0;
            credit_ok <= 1'b0;
        end
        else
        begin
            count     <= count_nxt;
            credit_ok <= (count_nxt >= CW'(ts_remap_pkg::OUT_WORDS));  // room for a full packet
        end
    end

endmodule

// ==== hw/remap_ctrl.sv ====
`timescale 1ns/1ps

module remap_ctrl #(
    parameter int TABLE_DEPTH = 16
) (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             pkt_ready,
    input  ts_remap_pkg::ts_word_t           head_word,
    input  ts_remap_pkg::route_entry_t       rd_entry,
    input  logic                             credit_ok,
    output logic [$clog2(TABLE_DEPTH)-1:0]   rd_index,
    output logic                             pop,
    output logic                             spend,
    output logic                             frame_en,
    output ts_remap_pkg::word_idx_t          frame_index,
    output ts_remap_pkg::route_entry_t       route
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    ts_remap_pkg::remap_state_t state;
    ts_remap_pkg::word_idx_t    word_idx;
    ts_remap_pkg::pid_t         head_pid;
    logic [IDX_W-1:0]           scan_idx;
    logic                       hit;

    assign head_pid = head_word[20:8];    // pid field of packet word 0
    assign hit      = rd_entry.valid && (rd_entry.pid == head_pid);
    assign rd_index = scan_idx;

    //////////////////////////////////////////////////
    // search, credit wait and word walk

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= ts_remap_pkg::st_idle;
            scan_idx <= '0;
            word_idx <= '0;
        end
        else
        begin
            case (state)
                ts_remap_pkg::st_idle:
                begin
                    scan_idx <= '0;
                    word_idx <= '0;
                    if (pkt_ready)
                        state <= ts_remap_pkg::st_search;
                end
                ts_remap_pkg::st_search:
                begin
                    if (hit)    // first match wins
                        state <= (rd_entry.port != '0) ? ts_remap_pkg::st_wait_credit
                                                       : ts_remap_pkg::st_discard;
                    else if (scan_idx == IDX_W'(TABLE_DEPTH - 1))
                        state <= ts_remap_pkg::st_discard;    // no entry
                    else
                        scan_idx <= scan_idx + 1'b1;
                end
                ts_remap_pkg::st_wait_credit:
                begin
                    if (credit_ok)
                        state <= ts_remap_pkg::st_send;
                end
                ts_remap_pkg::st_send:
                begin
                    word_idx <= word_idx + 1'b1;
                    if (word_idx == ts_remap_pkg::word_idx_t'(ts_remap_pkg::OUT_WORDS - 1))
                        state <= ts_remap_pkg::st_idle;
                end
                ts_remap_pkg::st_discard:
                begin
                    word_idx <= word_idx + 1'b1;
                    if (word_idx == ts_remap_pkg::word_idx_t'(ts_remap_pkg::TS_WORDS - 1))
                        state <= ts_remap_pkg::st_idle;
                end
                default:
                    state <= ts_remap_pkg::st_idle;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == ts_remap_pkg::st_search && hit)
            route <= rd_entry;
    end

    assign frame_en    = (state == ts_remap_pkg::st_send);
    assign frame_index = word_idx;
    assign spend       = frame_en;    // one credit per word out
    assign pop         = (state == ts_remap_pkg::st_discard) ||
                         (frame_en && word_idx >= ts_remap_pkg::word_idx_t'(ts_remap_pkg::HDR_WORDS));

endmodule

// ==== hw/route_header_framer.sv ====
`timescale 1ns/1ps

module route_header_framer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        frame_en,
    input  ts_remap_pkg::word_idx_t     frame_index,
    input  ts_remap_pkg::route_entry_t  route,
    input  ts_remap_pkg::ts_word_t      head_word,
    output ts_remap_pkg::ts_word_t      ts_dout,
    output logic                        ts_dout_en
);

    always_ff @(posedge clk)
    begin
        if (rst)
            ts_dout_en <= 1'b0;
        else
            ts_dout_en <= frame_en;
    end

    always_ff @(posedge clk)
    begin
        if (!frame_en)
            ts_dout <= '0;
        else
        begin
            case (frame_index)
                6'd0: ts_dout <= {1'b1, 16'd0, route.seq};    // start of packet
                6'd1: ts_dout <= {25'd0, route.sfp};
                6'd2: ts_dout <= {1'b0, route.ip};
                6'd3: ts_dout <= {17'd0, route.port};
                ts_remap_pkg::word_idx_t'(ts_remap_pkg::HDR_WORDS):
                    ts_dout <= {1'b0, head_word[31:21], route.new_pid, head_word[7:0]};
                default:
                    ts_dout <= {1'b0, head_word[31:0]};    // payload, start flag cleared
            endcase
        end
    end

endmodule

// ==== hw/ts_remap_top.sv ====
`timescale 1ns/1ps

module ts_remap_top #(
    parameter int TABLE_DEPTH = 16,
    parameter int BUF_DEPTH   = 128,
    parameter int CREDIT_MAX  = 64    // at least one full output packet
) (
    input  logic                    clk,
    input  logic                    rst,
    input  ts_remap_pkg::ts_word_t  ts_din,
    input  logic                    ts_din_en,
    input  logic [7:0]              cfg_din,
    input  logic                    cfg_din_en,
    input  logic                    credit_return,
    output ts_remap_pkg::ts_word_t  ts_dout,
    output logic                    ts_dout_en
);

    logic                             wr_en;
    logic [$clog2(TABLE_DEPTH)-1:0]   wr_index;
    ts_remap_pkg::route_entry_t       wr_entry;
    logic [$clog2(TABLE_DEPTH)-1:0]   rd_index;
    ts_remap_pkg::route_entry_t       rd_entry;
    ts_remap_pkg::ts_word_t           head_word;
    logic                             pkt_ready;
    logic                             pop;
    logic                             credit_ok;
    logic                             spend;
    logic                             frame_en;
    ts_remap_pkg::word_idx_t          frame_index;
    ts_remap_pkg::route_entry_t       route;

    route_cfg_parser #(.TABLE_DEPTH(TABLE_DEPTH)) i_parser (
        .clk(clk), .rst(rst), .cfg_din(cfg_din), .cfg_din_en(cfg_din_en),
        .wr_en(wr_en), .wr_index(wr_index), .wr_entry(wr_entry)
    );

    pid_route_table #(.TABLE_DEPTH(TABLE_DEPTH)) i_table (
        .clk(clk), .rst(rst), .wr_en(wr_en), .wr_index(wr_index), .wr_entry(wr_entry),
        .rd_index(rd_index), .rd_entry(rd_entry)
    );

    ts_packet_buffer #(.BUF_DEPTH(BUF_DEPTH)) i_buffer (
        .clk(clk), .rst(rst), .ts_din(ts_din), .ts_din_en(ts_din_en), .pop(pop),
        .head_word(head_word), .pkt_ready(pkt_ready)
    );

    egress_credit_counter #(.CREDIT_MAX(CREDIT_MAX)) i_credit (
        .clk(clk), .rst(rst), .credit_return(credit_return), .spend(spend),
        .credit_ok(credit_ok)
    );

    remap_ctrl #(.TABLE_DEPTH(TABLE_DEPTH)) i_ctrl (
        .clk(clk), .rst(rst), .pkt_ready(pkt_ready), .head_word(head_word),
        .rd_entry(rd_entry), .credit_ok(credit_ok), .rd_index(rd_index), .pop(pop),
        .spend(spend), .frame_en(frame_en), .frame_index(frame_index), .route(route)
    );

    route_header_framer i_framer (
        .clk(clk), .rst(rst), .frame_en(frame_en), .frame_index(frame_index),
        .route(route), .head_word(head_word), .ts_dout(ts_dout), .ts_dout_en(ts_dout_en)
    );

endmodule

// ==== testbench/tb_ts_remap.sv ====
`timescale 1ns/1ps

module tb_ts_remap;

    localparam int TABLE_DEPTH = 16;
    localparam int BUF_DEPTH   = 128;
    localparam int CREDIT_MAX  = 64;
    localparam int SETTLE      = TABLE_DEPTH + 60;    // search plus one packet out

    logic                   clk;
    logic                   rst;
    ts_remap_pkg::ts_word_t ts_din;
    logic                   ts_din_en;
    logic [7:0]             cfg_din;
    logic                   cfg_din_en;
    logic                   credit_return;
    ts_remap_pkg::ts_word_t ts_dout;
    logic                   ts_dout_en;

    ts_remap_pkg::ts_word_t got_q [$];
    ts_remap_pkg::ts_word_t exp_q [$];
    ts_remap_pkg::ts_word_t last_pkt [ts_remap_pkg::TS_WORDS];
    logic [31:0]            v [7];                // fields of the current command
    int                     budget = 200;         // watchdog limit in cycles, grows per command
    int                     wd_cycles;
    int                     bursts;
    int                     exp_pkts;
    int                     test_errs;
    int                     tests_run;
    int                     tests_failed;
    int                     word_checks;
    int                     total_errs;
    logic                   prev_en = 1'b0;

    ts_remap_top #(
        .TABLE_DEPTH(TABLE_DEPTH),
        .BUF_DEPTH(BUF_DEPTH),
        .CREDIT_MAX(CREDIT_MAX)
    ) i_dut (
        .clk(clk), .rst(rst), .ts_din(ts_din), .ts_din_en(ts_din_en),
        .cfg_din(cfg_din), .cfg_din_en(cfg_din_en), .credit_return(credit_return),
        .ts_dout(ts_dout), .ts_dout_en(ts_dout_en)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    //////////////////////////////////////////////////
    // output monitor

    always @(negedge clk)
    begin
        if (!rst && ts_dout_en)
            got_q.push_back(ts_dout);
        if (!rst && ts_dout_en && !prev_en)
            bursts++;    // one burst per packet
        prev_en = ts_dout_en;
    end

    //////////////////////////////////////////////////
    // stimulus drivers

    task automatic send_cfg(input int nbytes);
        logic [111:0] msg;
        msg = {v[0][7:0], v[1][15:0], v[2][15:0], v[3][7:0], v[4], v[5][15:0], v[6][15:0]};
        for (int b = 0; b < nbytes; b++)
        begin
            @(negedge clk);
            cfg_din    = msg[111 - 8 * b -: 8];    // big-endian
            cfg_din_en = 1'b1;
        end
        @(negedge clk);
        cfg_din_en = 1'b0;
    endtask

    task automatic send_pkt(input logic [12:0] pid);
        logic [31:0] rnd;
        for (int i = 0; i < ts_remap_pkg::TS_WORDS; i++)
        begin
            rnd = $urandom;
            if (i == 0)
                last_pkt[i] = {1'b1, rnd[31:21], pid, rnd[7:0]};
            else
                last_pkt[i] = {1'b0, rnd};
            @(negedge clk);
            ts_din    = last_pkt[i];
            ts_din_en = 1'b1;
        end
        @(negedge clk);
        ts_din_en = 1'b0;
    endtask

    task automatic give_credits(input int n);
        repeat (n)
        begin
            @(negedge clk);
            credit_return = 1'b1;
        end
        @(negedge clk);
        credit_return = 1'b0;
    endtask

    // header words then the last packet sent, pid swapped on word 0
    task automatic expect_fwd();
        logic [31:0] d;
        exp_q.push_back({1'b1, 16'h0, v[0][15:0]});
        exp_q.push_back({25'h0, v[1][7:0]});
        exp_q.push_back({1'b0, v[2]});
        exp_q.push_back({17'h0, v[3][15:0]});
        for (int i = 0; i < ts_remap_pkg::TS_WORDS; i++)
        begin
            d = last_pkt[i][31:0];
            if (i == 0)
                d[20:8] = v[4][12:0];
            exp_q.push_back({1'b0, d});
        end
        exp_pkts++;
    endtask

    task automatic check_quiet(input int n);
        repeat (n)
        begin
            @(negedge clk);
            if (ts_dout_en)
            begin
                $display("output valid went high during a %0d-cycle quiet window", n);
                test_errs++;
            end
        end
    endtask

    //////////////////////////////////////////////////
    // end of test: drain, compare, report

    task automatic finish_test(input string name);
        int idle;
        idle = 0;
        while (idle < SETTLE)    // no output for a whole packet time
        begin
            @(negedge clk);
            if (ts_dout_en)
                idle = 0;
            else
                idle++;
        end
        for (int i = 0; i < got_q.size() && i < exp_q.size(); i++)
        begin
            word_checks++;
            if (got_q[i] !== exp_q[i])
            begin
                $display("** Error: test %s word %0d expected %h actual %h",
                         name, i, exp_q[i], got_q[i]);
                test_errs++;
            end
        end
        if (got_q.size() != exp_q.size())
        begin
            $display("test %s: %0d output words arrived, %0d expected (packet missing or extra)",
                     name, got_q.size(), exp_q.size());
            test_errs++;
        end
        if (bursts != exp_pkts)
        begin
            $display("test %s: output came as %0d bursts for %0d forwarded packets",
                     name, bursts, exp_pkts);
            test_errs++;
        end
        tests_run++;
        if (test_errs == 0)
            $display("test %s: ok", name);
        else
        begin
            $display("test %s: FAILED with %0d errors", name, test_errs);
            tests_failed++;
        end
        total_errs += test_errs;
        test_errs   = 0;
        exp_pkts    = 0;
        bursts      = 0;
        got_q.delete();
        exp_q.delete();
    endtask

    task automatic run_command(input string line);
        string cmd;
        string name;
        int    n;
        n = $sscanf(line, "%s", cmd);
        if (cmd == "cfg" || cmd == "cut")
        begin
            n = $sscanf(line, "%s %h %h %h %h %h %h %h", cmd, v[0], v[1], v[2], v[3], v[4],
                        v[5], v[6]);
            budget += ts_remap_pkg::CFG_BYTES + 1;
            send_cfg((cmd == "cfg") ? ts_remap_pkg::CFG_BYTES : 7);
        end
        else if (cmd == "pkt")
        begin
            n = $sscanf(line, "%s %h", cmd, v[0]);
            budget += ts_remap_pkg::TS_WORDS + 1 + SETTLE;
            send_pkt(v[0][12:0]);
        end
        else if (cmd == "fwd")
        begin
            n = $sscanf(line, "%s %h %h %h %h %h", cmd, v[0], v[1], v[2], v[3], v[4]);
            expect_fwd();
        end
        else if (cmd == "credit" || cmd == "quiet")
        begin
            n = $sscanf(line, "%s %d", cmd, v[0]);
            budget += int'(v[0]) + 1;
            if (cmd == "credit")
                give_credits(int'(v[0]));
            else
                check_quiet(int'(v[0]));
        end
        else if (cmd == "end")
        begin
            n = $sscanf(line, "%s %s", cmd, name);
            budget += SETTLE;
            finish_test(name);
        end
        else if (cmd != "drop")    // drop expects no words
        begin
            $display("unknown stimulus command %s", cmd);
            test_errs++;
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog

    initial
    begin
        string line;
        int    fd;
        int    n;
        rst           = 1'b1;
        ts_din        = '0;
        ts_din_en     = 1'b0;
        cfg_din       = '0;
        cfg_din_en    = 1'b0;
        credit_return = 1'b0;
        n = $urandom(54);
        repeat (10) @(negedge clk);
        rst = 1'b0;
        fd = $fopen("testbench/ts_remap_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open testbench/ts_remap_stimulus.txt");
            $display("Checks failed");
            $finish;
        end
        else
        begin
            while (!$feof(fd))
            begin
                n = $fgets(line, fd);
                if (n > 1 && line.getc(0) != "#")
                    run_command(line);
            end
            $fclose(fd);
            total_errs += test_errs;    // anything after the last test end
            $display("tests: %0d run, %0d failed; word checks: %0d; errors: %0d",
                     tests_run, tests_failed, word_checks, total_errs);
            if (tests_run > 0 && tests_failed == 0 && total_errs == 0)
                $display("All checks passed");
            else
                $display("Checks failed");
            $finish;
        end
    end

    initial
    begin
        wd_cycles = 0;
        while (wd_cycles <= budget)
        begin
            @(posedge clk);
            wd_cycles++;
        end
        $display("watchdog: run exceeded its budget of %0d cycles", budget);
        $display("Checks failed");
        $finish;
    end

endmodule

// ==== testbench/ts_remap_stimulus.txt ====
# cfg|cut <idx> <pid> <seq> <sfp> <ip> <port> <new_pid> in hex; cut sends only 7 bytes
# pkt <pid> hex; fwd <seq> <sfp> <ip> <port> <new_pid> hex; drop; credit|quiet <n> decimal; end <name>
quiet 20
end reset_idle

cfg 0 0100 1234 03 c0a80101 1f90 0200
credit 51
pkt 0100
fwd 1234 03 c0a80101 1f90 0200
end basic_forward

cfg 1 0101 0001 01 0a000001 0000 0300
credit 51
pkt 0555
drop
pkt 0101
drop
pkt 0100
fwd 1234 03 c0a80101 1f90 0200
end unmapped_and_port_zero

cfg 2 0102 beef 07 ac100005 1388 00ff
credit 50
pkt 0100
fwd 1234 03 c0a80101 1f90 0200
pkt 0102
fwd beef 07 ac100005 1388 00ff
quiet 200
credit 1
credit 51
end credit_backpressure

cfg 3 0104 aaaa 10 e0000001 2710 0111
cfg 4 0104 bbbb 20 e0000002 2711 0222
credit 51
pkt 0104
fwd aaaa 10 e0000001 2710 0111
end duplicate_pid_priority

cfg 0 0100 4321 05 c0a80102 1f91 0201
credit 51
pkt 0100
fwd 4321 05 c0a80102 1f91 0201
end index_rewrite

cut 2 0102 9999 09 01020304 0000 0077
cut 5 0106 5555 01 01010101 1234 0066
credit 51
pkt 0102
fwd beef 07 ac100005 1388 00ff
pkt 0106
drop
end short_config_ignored

// ==== vlog.f ====
hw/ts_remap_pkg.sv
hw/route_cfg_parser.sv
hw/pid_route_table.sv
hw/ts_packet_buffer.sv
hw/egress_credit_counter.sv
hw/remap_ctrl.sv
hw/route_header_framer.sv
hw/ts_remap_top.sv
testbench/tb_ts_remap.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the remapper testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f vlog.f --top-module tb_ts_remap \
    --Mdir obj_dir -o tb_ts_remap
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tb_ts_remap)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

printf '%s\n' "$out" | grep -qx "All checks passed" || exit 1
exit 0
